// File: build.f
+incdir+.
fib_pkg.sv
fib_digit_stage.sv
fib_encoder.sv
fib_decoder.sv
fib_codec_top.sv
tb_fib_codec.sv

// File: fib_codec_top.sv
module fib_codec_top
    import fib_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Binary to code
    input  enc_in_t  enc_in,
    output enc_out_t enc_out,

    // Code to binary
    input  dec_in_t  dec_in,
    output dec_out_t dec_out
);

    // The two paths share only clock and reset
    fib_encoder u_encoder (
        .clk    (clk),
        .reset  (reset),
        .enc_in (enc_in),
        .enc_out(enc_out)
    );

    fib_decoder u_decoder (
        .clk    (clk),
        .reset  (reset),
        .dec_in (dec_in),
        .dec_out(dec_out)
    );

endmodule

// File: fib_decoder.sv
`include "fib_macros.svh"

module fib_decoder
    import fib_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  dec_in_t  dec_in,
    output dec_out_t dec_out
);

    localparam int       HALF      = `FIB_DIGITS / 2;
    localparam fib_sum_t VALUE_MAX = fib_sum_t'((1 << `FIB_VALUE_W) - 1);

    fib_sum_t                    sum_lo;
    fib_sum_t                    sum_hi;
    fib_sum_t                    sum_lo_q;
    fib_sum_t                    sum_hi_q;
    fib_sum_t                    total;
    logic [`FIB_DEC_LATENCY-1:0] valid_q;
    fib_value_t                  value_q;
    logic                        overflow_q;

    always_comb
    begin
        sum_lo = '0;
        sum_hi = '0;
        for (int k = 1; k <= HALF; k++)
        begin
            if (dec_in.code[k-1])
                sum_lo = sum_lo + fib_weight(k);
        end
        for (int k = HALF + 1; k <= `FIB_DIGITS; k++)
        begin
            if (dec_in.code[k-1])
                sum_hi = sum_hi + fib_weight(k);
        end
    end

    assign total = sum_lo_q + sum_hi_q;  // At most 28655, no carry out

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= {valid_q[`FIB_DEC_LATENCY-2:0], dec_in.valid};
        end
        sum_lo_q   <= sum_lo;
        sum_hi_q   <= sum_hi;
        value_q    <= total[`FIB_VALUE_W-1:0];
        overflow_q <= (total > VALUE_MAX);
    end

    assign dec_out = '{
        valid:    valid_q[`FIB_DEC_LATENCY-1],
        value:    value_q,
        overflow: overflow_q
    };

endmodule

// File: fib_digit_stage.sv
module fib_digit_stage
    import fib_pkg::*;
#(
    parameter int DIGIT = 1
)
(
    input  fib_value_t remainder_in,
    input  logic       prev_digit,
    output logic       digit,
    output fib_value_t remainder_out
);

    localparam fib_sum_t WEIGHT = fib_weight(DIGIT);
    localparam fib_sum_t LOWER  = fib_lower_sum(DIGIT);

    fib_sum_t rem_wide;

    assign rem_wide = fib_sum_t'(remainder_in);

    always_comb
    begin
        if (rem_wide > LOWER)
        begin
            digit = 1'b1;        // Lower digits cannot cover the rest
        end
        else if (rem_wide < WEIGHT)
        begin
            digit = 1'b0;
        end
        else
        begin
            digit = prev_digit;  // Free choice, keep the run going
        end

        if (digit)
        begin
            remainder_out = remainder_in - fib_value_t'(WEIGHT);
        end
        else
        begin
            remainder_out = remainder_in;
        end
    end

endmodule

// File: fib_encoder.sv
`include "fib_macros.svh"

module fib_encoder
    import fib_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  enc_in_t  enc_in,
    output enc_out_t enc_out
);

    localparam int GROUP    = `FIB_STAGE_GROUP;
    localparam int N_GROUPS = `FIB_ENC_LATENCY;

    // Per stage, index 0 handles the highest digit
    fib_value_t rem_in    [`FIB_DIGITS];
    fib_value_t rem_out   [`FIB_DIGITS];
    logic       prev_in   [`FIB_DIGITS];
    logic       digit_out [`FIB_DIGITS];
    fib_code_t  code_in   [`FIB_DIGITS];
    fib_code_t  code_out  [`FIB_DIGITS];

    // State entering and leaving each register group
    enc_state_t grp_in  [N_GROUPS];
    enc_state_t grp_out [N_GROUPS];

    assign grp_in[0] = '{
        valid:      enc_in.valid,
        remainder:  enc_in.value,
        code:       '0,
        last_digit: 1'b0             // Digit above the top counts as 0
    };

    for (genvar i = 0; i < `FIB_DIGITS; i++)
    begin : g_stage
        localparam int DIGIT = `FIB_DIGITS - i;
        localparam int GRP   = i / GROUP;

        if (i % GROUP == 0)
        begin : g_head
            assign rem_in[i]  = grp_in[GRP].remainder;
            assign prev_in[i] = grp_in[GRP].last_digit;
            assign code_in[i] = grp_in[GRP].code;
        end
        else
        begin : g_link
            assign rem_in[i]  = rem_out[i-1];
            assign prev_in[i] = digit_out[i-1];
            assign code_in[i] = code_out[i-1];
        end

        fib_digit_stage #(
            .DIGIT(DIGIT)
        ) u_digit (
            .remainder_in (rem_in[i]),
            .prev_digit   (prev_in[i]),
            .digit        (digit_out[i]),
            .remainder_out(rem_out[i])
        );

        assign code_out[i] = code_in[i] | (fib_code_t'(digit_out[i]) << (DIGIT - 1));
    end

    for (genvar g = 0; g < N_GROUPS; g++)
    begin : g_group
        localparam int TAIL = (g + 1) * GROUP - 1;

        enc_state_t state_q;

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                state_q.valid <= 1'b0;
            end
            else
            begin
                state_q.valid <= grp_in[g].valid;
            end
            state_q.remainder  <= rem_out[TAIL];
            state_q.code       <= code_out[TAIL];
            state_q.last_digit <= digit_out[TAIL];
        end

        assign grp_out[g] = state_q;

        if (g > 0)
        begin : g_chain
            assign grp_in[g] = grp_out[g-1];
        end
    end

    assign enc_out = '{
        valid: grp_out[N_GROUPS-1].valid,
        code:  grp_out[N_GROUPS-1].code
    };

endmodule

// File: fib_macros.svh
`ifndef FIB_MACROS_SVH
`define FIB_MACROS_SVH

// Width of a binary value
`define FIB_VALUE_W 14

// Code digits, weights 1, 2, 3, 5 up to 10946
`define FIB_DIGITS 20

// Digit stages per encoder register group
// 1, 2, 4, 5, 10 and 20 all divide the digit count
`define FIB_STAGE_GROUP 5

// One register per stage group
`define FIB_ENC_LATENCY (`FIB_DIGITS / `FIB_STAGE_GROUP)

// Partial sums, then final add
`define FIB_DEC_LATENCY 2

`endif

// File: fib_pkg.sv
`include "fib_macros.svh"

package fib_pkg;

    typedef logic [`FIB_VALUE_W-1:0] fib_value_t;
    typedef logic [`FIB_VALUE_W:0]   fib_sum_t;    // Holds the full weight total 28655
    typedef logic [`FIB_DIGITS-1:0]  fib_code_t;   // Bit k-1 is digit k

    typedef struct packed {
        logic       valid;
        fib_value_t value;
    } enc_in_t;

    typedef struct packed {
        logic      valid;
        fib_code_t code;
    } enc_out_t;

    typedef struct packed {
        logic       valid;
        fib_value_t remainder;
        fib_code_t  code;        // Digits chosen so far
        logic       last_digit;  // Lowest digit chosen so far
    } enc_state_t;

    typedef struct packed {
        logic      valid;
        fib_code_t code;
    } dec_in_t;

    typedef struct packed {
        logic       valid;
        fib_value_t value;
        logic       overflow;
    } dec_out_t;

    // Weight of digit k is F(k+1)
    function automatic fib_sum_t fib_weight(input int k);
        int a;
        int b;
        int t;
        a = 1;
        b = 1;
        for (int i = 1; i < k; i++)
        begin
            t = a + b;
            a = b;
            b = t;
        end
        return fib_sum_t'(b);
    endfunction

    // Sum of weights of digits 1 to k-1
    function automatic fib_sum_t fib_lower_sum(input int k);
        fib_sum_t s;
        s = '0;
        for (int j = 1; j < k; j++)
            s = s + fib_weight(j);
        return s;
    endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f build.f \
    --top-module tb_fib_codec \
    --Mdir obj_dir \
    -o tb_fib_codec

./obj_dir/tb_fib_codec > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tb_fib_model.svh
`ifndef TB_FIB_MODEL_SVH
`define TB_FIB_MODEL_SVH

// Weight of digit k, a Fibonacci sequence that starts 1, 2
function automatic int model_weight(input int k);
    int a;
    int b;
    int t;
    a = 1;                 // Digit 1
    b = 2;                 // Digit 2
    for (int i = 1; i < k; i++)
    begin
        t = a + b;
        a = b;
        b = t;
    end
    return a;
endfunction

function automatic int model_lower_sum(input int k);
    int s;
    s = 0;
    for (int j = 1; j < k; j++)
        s = s + model_weight(j);
    return s;
endfunction

// Highest digit first, free digits copy the digit above
function automatic logic [`FIB_DIGITS-1:0] model_encode(input logic [`FIB_VALUE_W-1:0] value);
    int                     r;
    int                     w;
    int                     low;
    logic                   prev;
    logic                   d;
    logic [`FIB_DIGITS-1:0] code;
    r    = int'(value);
    prev = 1'b0;
    code = '0;
    for (int k = `FIB_DIGITS; k >= 1; k--)
    begin
        w   = model_weight(k);
        low = model_lower_sum(k);
        if (r > low)
            d = 1'b1;
        else if (r < w)
            d = 1'b0;
        else
            d = prev;
        if (d)
            r = r - w;
        code[k-1] = d;
        prev      = d;
    end
    return code;
endfunction

// Full weighted sum, not truncated
function automatic int model_decode_sum(input logic [`FIB_DIGITS-1:0] code);
    int sum;
    sum = 0;
    for (int k = 1; k <= `FIB_DIGITS; k++)
    begin
        if (code[k-1])
            sum = sum + model_weight(k);
    end
    return sum;
endfunction

`endif

// File: tb_fib_codec.sv
`include "fib_macros.svh"

module tb_fib_codec
    import fib_pkg::*;
();

    localparam int N_IDLE    = 8;
    localparam int N_CORNER  = 3 + `FIB_DIGITS;
    localparam int N_RANDOM  = 2000;
    localparam int N_DRAIN   = 12;
    localparam int N_CYCLES  = 4 + N_IDLE + N_CORNER + N_RANDOM + N_DRAIN;
    localparam int ENC_LAT   = `FIB_ENC_LATENCY;
    localparam int DEC_LAT   = `FIB_DEC_LATENCY;
    localparam int VALUE_MAX = (1 << `FIB_VALUE_W) - 1;

    logic     clk;
    logic     reset;
    enc_in_t  enc_in;
    enc_out_t enc_out;
    dec_in_t  dec_in;
    dec_out_t dec_out;

    integer seed;
    int     cyc;
    int     checks;
    int     value_errors;
    int     flow_errors;

    // Expected results in arrival order
    int         enc_due_q[$];
    fib_value_t enc_value_q[$];
    fib_code_t  enc_code_q[$];
    int         dec_due_q[$];
    fib_value_t dec_value_q[$];
    logic       dec_ovf_q[$];

    fib_codec_top uut (
        .clk    (clk),
        .reset  (reset),
        .enc_in (enc_in),
        .enc_out(enc_out),
        .dec_in (dec_in),
        .dec_out(dec_out)
    );

    `include "tb_fib_model.svh"

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual)
        begin
            value_errors++;
            $display("error at %0t: %s, expected %0h, got %0h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_decoder();
        if (dec_out.valid)
        begin
            if (dec_due_q.size() == 0)
            begin
                flow_errors++;
                $display("decoder gave a result at %0t with nothing pending", $time);
            end
            else
            begin
                check_value("decoder latency", 32'(dec_due_q.pop_front()), 32'(cyc));
                check_value("decoded value", 32'(dec_value_q.pop_front()), 32'(dec_out.value));
                check_value("decoder overflow", 32'(dec_ovf_q.pop_front()),
                            32'(dec_out.overflow));
            end
        end
        else if (dec_due_q.size() != 0 && dec_due_q[0] <= cyc)
        begin
            flow_errors++;
            $display("decoder result missing at %0t", $time);
            void'(dec_due_q.pop_front());
            void'(dec_value_q.pop_front());
            void'(dec_ovf_q.pop_front());
        end
    endtask

    // Hands back each finished code for the round trip
    task automatic check_encoder(output logic rt_valid, output fib_code_t rt_code,
                                 output fib_value_t rt_value);
        rt_valid = 1'b0;
        rt_code  = '0;
        rt_value = '0;
        if (enc_out.valid)
        begin
            if (enc_due_q.size() == 0)
            begin
                flow_errors++;
                $display("encoder gave a code at %0t with nothing pending", $time);
            end
            else
            begin
                check_value("encoder latency", 32'(enc_due_q.pop_front()), 32'(cyc));
                rt_value = enc_value_q.pop_front();
                check_value("encoded code", 32'(enc_code_q.pop_front()), 32'(enc_out.code));
                rt_valid = 1'b1;
                rt_code  = enc_out.code;
            end
        end
        else if (enc_due_q.size() != 0 && enc_due_q[0] <= cyc)
        begin
            flow_errors++;
            $display("encoder code missing at %0t", $time);
            void'(enc_due_q.pop_front());
            void'(enc_value_q.pop_front());
            void'(enc_code_q.pop_front());
        end
    endtask

    // Samples outputs just after the edge, then drives the next inputs
    task automatic run_cycle(input logic ev, input fib_value_t evalue,
                             input logic dv, input fib_code_t dcode);
        logic       rt_valid;
        fib_code_t  rt_code;
        fib_value_t rt_value;
        int         sum;
        @(posedge clk);
        #1;
        cyc++;
        check_decoder();
        check_encoder(rt_valid, rt_code, rt_value);
        enc_in.valid = ev;
        enc_in.value = evalue;
        if (ev)
        begin
            enc_due_q.push_back(cyc + ENC_LAT);
            enc_value_q.push_back(evalue);
            enc_code_q.push_back(model_encode(evalue));
        end
        if (rt_valid)
        begin
            dec_in.valid = 1'b1;           // Round trip takes priority
            dec_in.code  = rt_code;
            dec_due_q.push_back(cyc + DEC_LAT);
            dec_value_q.push_back(rt_value);
            dec_ovf_q.push_back(1'b0);
        end
        else
        begin
            dec_in.valid = dv;
            dec_in.code  = dcode;
            if (dv)
            begin
                sum = model_decode_sum(dcode);
                dec_due_q.push_back(cyc + DEC_LAT);
                dec_value_q.push_back(fib_value_t'(sum));
                dec_ovf_q.push_back(sum > VALUE_MAX);
            end
        end
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] rnd_code;
        seed         = 32'hbd62dc11;
        cyc          = 0;
        checks       = 0;
        value_errors = 0;
        flow_errors  = 0;
        reset        = 1'b1;
        enc_in       = '0;
        dec_in       = '0;
        enc_in.valid = 1'b1;     // Pipelines fill with items unless reset clears them
        dec_in.valid = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset        = 1'b0;
        enc_in.valid = 1'b0;
        dec_in.valid = 1'b0;

        for (int n = 0; n < N_IDLE; n++)
        begin
            run_cycle(1'b0, '0, 1'b0, '0);
            check_value("encoder valid while idle", 32'h0, 32'(enc_out.valid));
            check_value("decoder valid while idle", 32'h0, 32'(dec_out.valid));
        end

        // Corner values back to back, all-ones code alongside the first
        run_cycle(1'b1, fib_value_t'(0), 1'b1, '1);
        run_cycle(1'b1, fib_value_t'(1), 1'b0, '0);
        run_cycle(1'b1, fib_value_t'(VALUE_MAX), 1'b0, '0);
        for (int k = 1; k <= `FIB_DIGITS; k++)
            run_cycle(1'b1, fib_value_t'(model_weight(k)), 1'b0, '0);

        for (int n = 0; n < N_RANDOM; n++)
        begin
            rnd      = $random(seed);
            rnd_code = $random(seed);
            run_cycle(rnd[1:0] != 2'b00, rnd[15:2], rnd[17:16] != 2'b00, rnd_code[19:0]);
        end

        for (int n = 0; n < N_DRAIN && (enc_due_q.size() != 0 || dec_due_q.size() != 0); n++)
            run_cycle(1'b0, '0, 1'b0, '0);
        if (enc_due_q.size() != 0 || dec_due_q.size() != 0)
        begin
            flow_errors++;
            $display("results still pending at the end of the test");
        end

        $display("checks %0d, value errors %0d, flow errors %0d",
                 checks, value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        #((N_CYCLES + 20) * 4);
        $display("simulation timed out after %0d cycles", N_CYCLES + 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule
